// ==== retire_mix_pkg.sv ====
// retire mix profiler shared definitions
// instruction and retire slot types, opcode and marker constants,
// and the instruction mix category encoding

package retire_mix_pkg;

    ////////////////////
    // instruction and slot types

    typedef logic [31:0] instr_t;

    typedef struct packed {
        logic   valid;
        instr_t instr;
    } retire_slot_t;

    // slot after the window decision
    typedef struct packed {
        logic   counted;
        instr_t instr;
    } counted_slot_t;

    ////////////////////
    // instruction mix categories

    typedef enum logic [2:0] {
        CAT_ALU    = 3'd0,
        CAT_BRANCH = 3'd1,
        CAT_MUL    = 3'd2,
        CAT_DIV    = 3'd3,
        CAT_LOAD   = 3'd4,
        CAT_STORE  = 3'd5,
        CAT_MISC   = 3'd6
    } mix_cat_e;

    localparam int NUM_MIX_CATS = 7;

    // msb first so that bit position equals the category value
    typedef struct packed {
        logic misc;
        logic store;
        logic load;
        logic div;
        logic mul;
        logic branch;
        logic alu;
    } mix_flags_t;

    ////////////////////
    // opcodes, instruction bits 6:2

    localparam logic [4:0] OPC_LOAD      = 5'b00000;
    localparam logic [4:0] OPC_STORE     = 5'b01000;
    localparam logic [4:0] OPC_BRANCH    = 5'b11000;
    localparam logic [4:0] OPC_JAL       = 5'b11011;
    localparam logic [4:0] OPC_JALR      = 5'b11001;
    localparam logic [4:0] OPC_ARITH     = 5'b01100;
    localparam logic [4:0] OPC_ARITH_IMM = 5'b00100;
    localparam logic [4:0] OPC_AUIPC     = 5'b00101;
    localparam logic [4:0] OPC_LUI       = 5'b01101;
    localparam logic [4:0] OPC_AMO       = 5'b01011;
    localparam logic [4:0] OPC_FENCE     = 5'b00011;
    localparam logic [4:0] OPC_SYSTEM    = 5'b11100;

    // collection window markers, both addi no-ops
    localparam instr_t START_MARKER = 32'h00C00013;
    localparam instr_t END_MARKER   = 32'h00D00013;

endpackage

// ==== retire_capture.sv ====
// retire capture stage
// registers the retire ports, spots the window markers and
// keeps the collection window state for the profiler

`timescale 1ns/1ps
`default_nettype none

module retire_capture #(
    parameter int RETIRE_PORTS = 2
) (
    input  logic                          clk,
    input  logic                          rst,
    input  retire_mix_pkg::retire_slot_t  retire_slots [RETIRE_PORTS],
    output retire_mix_pkg::counted_slot_t counted_slots [RETIRE_PORTS],
    output logic                          clear,
    output logic                          collecting
);
    import retire_mix_pkg::*;

    logic start_seen;
    logic end_seen;
    logic is_marker [RETIRE_PORTS];
    logic counted_d [RETIRE_PORTS];
    logic clear_q;

    ////////////////////
    // marker detection

    always_comb begin
        start_seen = 1'b0;
        end_seen = 1'b0;
        foreach (retire_slots[i]) begin
            is_marker[i] = (retire_slots[i].instr == START_MARKER) ||
                           (retire_slots[i].instr == END_MARKER);
            start_seen |= retire_slots[i].valid && (retire_slots[i].instr == START_MARKER);
            end_seen |= retire_slots[i].valid && (retire_slots[i].instr == END_MARKER);
        end
    end

    // window as it stood before this cycle's markers
    always_comb begin
        foreach (retire_slots[i]) begin
            counted_d[i] = retire_slots[i].valid && !is_marker[i] && collecting;
        end
    end

    ////////////////////
    // window state

    // end marker wins when both show up together
    always_ff @(posedge clk) begin
        if (rst) begin
            collecting <= 1'b0;
        end else if (end_seen) begin
            collecting <= 1'b0;
        end else if (start_seen) begin
            collecting <= 1'b1;
        end
    end

    ////////////////////
    // slot registers

    always_ff @(posedge clk) begin
        foreach (counted_slots[i]) begin
            if (rst) begin
                counted_slots[i].counted <= 1'b0;
            end else begin
                counted_slots[i].counted <= counted_d[i];
            end
            counted_slots[i].instr <= retire_slots[i].instr;
        end
    end

    // clear rides two stages to meet the classifier flags
    always_ff @(posedge clk) begin
        if (rst) begin
            clear_q <= 1'b0;
            clear <= 1'b0;
        end else begin
            clear_q <= start_seen && !end_seen;
            clear <= clear_q;
        end
    end

    ////////////////////
    // checks

    for (genvar i = 0; i < RETIRE_PORTS; i++) begin : g_chk
        // an empty slot never turns into a counted one
        assert property (@(posedge clk) disable iff (rst)
            !$past(retire_slots[i].valid) |-> !counted_slots[i].counted);
    end

endmodule

`default_nettype wire

// ==== retire_classifier.sv ====
// retire slot classifier
// decodes one captured instruction into instruction mix flags
// and registers them for the counters

`timescale 1ns/1ps
`default_nettype none

module retire_classifier (
    input  logic                          clk,
    input  logic                          rst,
    input  retire_mix_pkg::counted_slot_t slot,
    output retire_mix_pkg::mix_flags_t    flags
);
    import retire_mix_pkg::*;

    localparam mix_flags_t AMO_FLAGS = '{load: 1'b1, store: 1'b1, default: 1'b0};

    logic [4:0] opcode;
    logic       is_arith;
    logic       is_mul;
    logic       is_div;
    logic [NUM_MIX_CATS-1:0] flag_bits;

    assign opcode = slot.instr[6:2];
    assign is_arith = (opcode == OPC_ARITH);

    // only the register form of arith carries mul and div
    assign is_mul = is_arith && slot.instr[25] && !slot.instr[14];
    assign is_div = is_arith && slot.instr[25] && slot.instr[14];

    ////////////////////
    // category decode

    always_comb begin
        flag_bits = '0;
        flag_bits[CAT_ALU] = (is_arith && !is_mul && !is_div) ||
                             (opcode inside {OPC_ARITH_IMM, OPC_AUIPC, OPC_LUI});
        flag_bits[CAT_BRANCH] = opcode inside {OPC_BRANCH, OPC_JAL, OPC_JALR};
        flag_bits[CAT_MUL] = is_mul;
        flag_bits[CAT_DIV] = is_div;
        // amo lands in both load and store
        flag_bits[CAT_LOAD] = opcode inside {OPC_LOAD, OPC_AMO};
        flag_bits[CAT_STORE] = opcode inside {OPC_STORE, OPC_AMO};
        flag_bits[CAT_MISC] = opcode inside {OPC_SYSTEM, OPC_FENCE};
    end

    ////////////////////
    // flag register

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (slot.counted) begin
            flags <= mix_flags_t'(flag_bits);
        end else begin
            flags <= '0;
        end
    end

    ////////////////////
    // checks

    // categories are exclusive apart from amo
    assert property (@(posedge clk) disable iff (rst)
        ($countones(flags) < 2) || (flags == AMO_FLAGS));

endmodule

`default_nettype wire

// ==== mix_counters.sv ====
// instruction mix counters
// adds up the category flags of all retire lanes each cycle
// and keeps one running count per category

`timescale 1ns/1ps
`default_nettype none

module mix_counters #(
    parameter int RETIRE_PORTS = 2,
    parameter int COUNT_W = 32
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       clear,
    input  retire_mix_pkg::mix_flags_t lane_flags [RETIRE_PORTS],
    output logic [retire_mix_pkg::NUM_MIX_CATS-1:0][COUNT_W-1:0] counts
);
    import retire_mix_pkg::*;

    // wide enough to hold RETIRE_PORTS
    localparam int LANE_W = $clog2(RETIRE_PORTS + 1);

    logic [NUM_MIX_CATS-1:0] lane_bits [RETIRE_PORTS];
    logic [LANE_W-1:0]       lane_sum [NUM_MIX_CATS];
    logic [NUM_MIX_CATS-1:0][COUNT_W-1:0] next_counts;

    ////////////////////
    // per category lane sum

    always_comb begin
        foreach (lane_flags[l]) begin
            lane_bits[l] = lane_flags[l];
        end
    end

    always_comb begin
        for (int c = 0; c < NUM_MIX_CATS; c++) begin
            lane_sum[c] = '0;
            for (int l = 0; l < RETIRE_PORTS; l++) begin
                lane_sum[c] += LANE_W'(lane_bits[l][c]);
            end
        end
    end

    ////////////////////
    // accumulate

    // clear first, then this beat's flags go on top
    always_comb begin
        for (int c = 0; c < NUM_MIX_CATS; c++) begin
            if (clear) begin
                next_counts[c] = COUNT_W'(lane_sum[c]);
            end else begin
                next_counts[c] = counts[c] + COUNT_W'(lane_sum[c]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            counts <= '0;
        end else begin
            counts <= next_counts;
        end
    end

    ////////////////////
    // checks

    for (genvar c = 0; c < NUM_MIX_CATS; c++) begin : g_chk
        // a growing count must end up larger, otherwise it wrapped
        assert property (@(posedge clk) disable iff (rst)
            (!clear && (lane_sum[c] != '0)) |=> (counts[c] > $past(counts[c])));
    end

endmodule

`default_nettype wire

// ==== retire_mix_profiler.sv ====
// retire trace instruction mix profiler
// counts retired instructions per category between the start
// and end marker no-ops, three cycles behind the retire ports

`timescale 1ns/1ps
`default_nettype none

module retire_mix_profiler #(
    parameter int RETIRE_PORTS = 2,
    parameter int COUNT_W = 32
) (
    input  logic                         clk,
    input  logic                         rst,
    input  retire_mix_pkg::retire_slot_t retire_slots [RETIRE_PORTS],
    output logic [retire_mix_pkg::NUM_MIX_CATS-1:0][COUNT_W-1:0] counts,
    output logic                         collecting
);
    import retire_mix_pkg::*;

    counted_slot_t counted_slots [RETIRE_PORTS];
    mix_flags_t    lane_flags [RETIRE_PORTS];
    logic          clear;

    ////////////////////
    // capture and window

    retire_capture #(
        .RETIRE_PORTS(RETIRE_PORTS)
    ) capture0 (
        .clk(clk),
        .rst(rst),
        .retire_slots(retire_slots),
        .counted_slots(counted_slots),
        .clear(clear),
        .collecting(collecting)
    );

    ////////////////////
    // one classifier per retire lane

    for (genvar i = 0; i < RETIRE_PORTS; i++) begin : g_lane
        retire_classifier classifier0 (
            .clk(clk),
            .rst(rst),
            .slot(counted_slots[i]),
            .flags(lane_flags[i])
        );
    end

    mix_counters #(
        .RETIRE_PORTS(RETIRE_PORTS),
        .COUNT_W(COUNT_W)
    ) counters0 (
        .clk(clk),
        .rst(rst),
        .clear(clear),
        .lane_flags(lane_flags),
        .counts(counts)
    );

endmodule

`default_nettype wire

// ==== tb_retire_mix_profiler.sv ====
// testbench for the retire mix profiler
// replays the retire trace from the test data file and checks the
// collection window and the category counts at each expected line

`timescale 1ns/1ps
`default_nettype none

module tb_retire_mix_profiler;
    import retire_mix_pkg::*;

    localparam int RETIRE_PORTS = 2;
    localparam int COUNT_W = 32;
    // retirement to counts output, in rising edges
    localparam int LATENCY = 3;
    localparam int RESET_CYCLES = 4;
    localparam int MAX_LINES = 200;
    localparam string DATA_FILE = "retire_mix_testdata.txt";

    logic clk;
    logic rst;
    retire_slot_t retire_slots [RETIRE_PORTS];
    logic [NUM_MIX_CATS-1:0][COUNT_W-1:0] counts;
    logic collecting;

    int fd;
    int code;
    int line_count;
    int checks_done;
    bit done;
    logic [7:0] tag;
    logic [8*160-1:0] comment_line;
    logic [31:0] valid0;
    logic [31:0] instr0;
    logic [31:0] valid1;
    logic [31:0] instr1;
    logic [31:0] want_collecting;
    logic [31:0] want_counts [NUM_MIX_CATS];

    retire_mix_profiler #(
        .RETIRE_PORTS(RETIRE_PORTS),
        .COUNT_W(COUNT_W)
    ) dut0 (
        .clk(clk),
        .rst(rst),
        .retire_slots(retire_slots),
        .counts(counts),
        .collecting(collecting)
    );

    ////////////////////
    // clock, 100 ns period

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    ////////////////////
    // helpers

    task automatic stop_with_failure();
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string field, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, field, got, want);
            stop_with_failure();
        end
    endtask

    function automatic string cat_name(input mix_cat_e cat);
        case (cat)
            CAT_ALU: return "alu count";
            CAT_BRANCH: return "branch count";
            CAT_MUL: return "mul count";
            CAT_DIV: return "div count";
            CAT_LOAD: return "load count";
            CAT_STORE: return "store count";
            default: return "misc count";
        endcase
    endfunction

    // one rising edge, then the input skew
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic drive_slots(input logic v0, input instr_t i0, input logic v1, input instr_t i1);
        retire_slots[0] = '{valid: v0, instr: i0};
        retire_slots[1] = '{valid: v1, instr: i1};
    endtask

    // idle through the pipeline, then compare against the expected line
    task automatic check_expected();
        drive_slots(1'b0, '0, 1'b0, '0);
        repeat (LATENCY) next_cycle();
        check_value("collecting", 32'(collecting), want_collecting);
        for (int c = 0; c < NUM_MIX_CATS; c++) begin
            check_value(cat_name(mix_cat_e'(c)), counts[c], want_counts[c]);
        end
        checks_done++;
    endtask

    ////////////////////
    // main sequence

    initial begin
        rst = 1'b1;
        drive_slots(1'b0, '0, 1'b0, '0);
        line_count = 0;
        checks_done = 0;
        done = 1'b0;

        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("could not open the test data file %s", DATA_FILE);
            stop_with_failure();
        end

        repeat (RESET_CYCLES) next_cycle();
        rst = 1'b0;

        // bounded by the line count, so a runaway file cannot hang the run
        while (!done && line_count < MAX_LINES) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                line_count++;
                case (tag)
                    "#": begin
                        code = $fgets(comment_line, fd);
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h %h %h", valid0, instr0, valid1, instr1);
                        if (code != 4) begin
                            $display("stimulus line %0d is incomplete", line_count);
                            stop_with_failure();
                        end
                        drive_slots(valid0[0], instr0, valid1[0], instr1);
                        next_cycle();
                    end
                    "C": begin
                        code = $fscanf(fd, "%h %d %d %d %d %d %d %d", want_collecting,
                                       want_counts[0], want_counts[1], want_counts[2],
                                       want_counts[3], want_counts[4], want_counts[5],
                                       want_counts[6]);
                        if (code != 1 + NUM_MIX_CATS) begin
                            $display("expected-count line %0d is incomplete", line_count);
                            stop_with_failure();
                        end
                        check_expected();
                    end
                    default: begin
                        $display("line %0d of the test data file has an unknown type", line_count);
                        stop_with_failure();
                    end
                endcase
            end
        end
        $fclose(fd);

        if (!done) begin
            $display("test data file runs past %0d lines, giving up", MAX_LINES);
            stop_with_failure();
        end else if (checks_done == 0) begin
            $display("test data file holds no expected-count lines");
            stop_with_failure();
        end else begin
            $display("%0d expected-count lines checked", checks_done);
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== retire_mix_testdata.txt ====
# R valid0 instr0 valid1 instr1 (hex), one retire cycle
# C collecting alu branch mul div load store misc (decimal), checked after 3 idle edges
C 0 0 0 0 0 0 0 0
# outside the window nothing counts
R 1 00100093 1 022081B3
R 1 0000A283 0 0050A023
# start marker with its valid bit low does not open the window
R 0 00C00013 0 00000000
C 0 0 0 0 0 0 0 0
# start marker on port 0, the add beside it is not counted
R 1 00C00013 1 002081B3
C 1 0 0 0 0 0 0 0
# addi add
R 1 00100093 1 002081B3
# mul div
R 1 022081B3 1 0220C1B3
# beq jal
R 1 00000463 1 010000EF
# jalr lui
R 1 00008067 1 123452B7
# auipc, ecall with valid low
R 1 00001297 0 00000073
# lw sw
R 1 0000A283 1 0050A023
# fence ecall
R 1 0FF0000F 1 00000073
C 1 4 3 1 1 1 1 2
# amoadd.w is load and store, addi with bit 25 set is alu
R 1 0020A2AF 1 02000093
# xori with bits 25 and 14 set is alu, divu is div
R 1 02004093 1 0220D1B3
# mul with valid low, mulh
R 0 022081B3 1 022091B3
C 1 6 3 2 2 2 2 2
# end marker on port 1, the lw beside it still counts
R 1 0000A283 1 00D00013
C 0 6 3 2 2 3 2 2
# closed window freezes the counts
R 1 002081B3 1 0050A023
R 1 00D00013 1 022081B3
C 0 6 3 2 2 3 2 2
# second start clears, the beq beside it is not counted
R 1 00000463 1 00C00013
R 1 0020A2AF 1 00000073
C 1 0 0 0 0 1 1 1
# start marker while open restarts the count
R 1 022081B3 0 00000000
R 0 00000000 1 00C00013
R 1 0220C1B3 1 00100093
C 1 1 0 0 1 0 0 0
# both markers together, the end marker wins and nothing is cleared
R 1 00C00013 1 00D00013
C 0 1 0 0 1 0 0 0
R 1 00100093 1 00000073
C 0 1 0 0 1 0 0 0

// ==== sources.f ====
retire_mix_pkg.sv
retire_capture.sv
retire_classifier.sv
mix_counters.sv
retire_mix_profiler.sv
tb_retire_mix_profiler.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the retire mix profiler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_retire_mix_profiler \
    --Mdir obj_dir -o sim_retire_mix \
    -f sources.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/sim_retire_mix
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0
